// File: udp_ctrl_regs.f
+incdir+verif
source/udp_ctrl_pkg.sv
source/axil_reg_slave.sv
source/board_param_regs.sv
source/dest_cell_stage.sv
source/udp_ctrl_regs.sv
verif/udp_ctrl_regs_tb.sv

// File: Makefile
# verilator flow for the register block and its testbench
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f udp_ctrl_regs.f --top-module udp_ctrl_regs

# the run counts as failed when the log holds the fail line or lacks the pass line
sim:
	verilator --binary --timing --assert -f udp_ctrl_regs.f \
		--top-module udp_ctrl_regs_tb -Mdir obj_dir -o sim_udp_ctrl_regs
	./obj_dir/sim_udp_ctrl_regs | tee sim.log
	@grep -q "TEST PASSED" sim.log
	@! grep -q "TEST FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: verif/axil_bfm_tasks.svh
`ifndef AXIL_BFM_TASKS_SVH
`define AXIL_BFM_TASKS_SVH

// one write, aw and w presented together, response held off for a random time
task automatic axil_write(input udp_ctrl_pkg::reg_idx_t idx, input udp_ctrl_pkg::word_t data,
                          input udp_ctrl_pkg::strb_t strb);
    int delay;
    delay = $unsigned($random(seed)) % 8;
    @(negedge clk);
    s_axil_awaddr_i  = {idx, 2'b00};
    s_axil_wdata_i   = data;
    s_axil_wstrb_i   = strb;
    s_axil_awvalid_i = 1'b1;
    s_axil_wvalid_i  = 1'b1;
    @(negedge clk);
    while (!s_axil_awready_o)
        @(negedge clk);
    // handshake takes place on the rising edge in between
    @(negedge clk);
    s_axil_awvalid_i = 1'b0;
    s_axil_wvalid_i  = 1'b0;
    model_write(idx, data, strb);
    while (!s_axil_bvalid_o)
        @(negedge clk);
    repeat (delay) @(negedge clk);
    s_axil_bready_i = 1'b1;
    @(negedge clk);
    s_axil_bready_i = 1'b0;
    wr_issued++;
endtask

// one read, expected word taken from the model before the request
task automatic axil_read(input udp_ctrl_pkg::reg_idx_t idx);
    int delay;
    delay = $unsigned($random(seed)) % 8;
    exp_rdata = model_read(idx);
    @(negedge clk);
    s_axil_araddr_i  = {idx, 2'b00};
    s_axil_arvalid_i = 1'b1;
    while (!s_axil_arready_o)
        @(negedge clk);
    @(negedge clk);
    s_axil_arvalid_i = 1'b0;
    while (!s_axil_rvalid_o)
        @(negedge clk);
    repeat (delay) @(negedge clk);
    s_axil_rready_i = 1'b1;
    @(negedge clk);
    s_axil_rready_i = 1'b0;
    rd_issued++;
endtask

`endif

// File: verif/udp_ctrl_regs_tb.sv
`timescale 1ns/1ps

module udp_ctrl_regs_tb;

    localparam int TIMEOUT_CYCLES = 5000;

    logic                        clk;
    logic                        reset_n;
    udp_ctrl_pkg::axil_addr_t    s_axil_awaddr_i;
    logic                        s_axil_awvalid_i;
    logic                        s_axil_awready_o;
    udp_ctrl_pkg::word_t         s_axil_wdata_i;
    udp_ctrl_pkg::strb_t         s_axil_wstrb_i;
    logic                        s_axil_wvalid_i;
    logic                        s_axil_wready_o;
    logic [1:0]                  s_axil_bresp_o;
    logic                        s_axil_bvalid_o;
    logic                        s_axil_bready_i;
    udp_ctrl_pkg::axil_addr_t    s_axil_araddr_i;
    logic                        s_axil_arvalid_i;
    logic                        s_axil_arready_o;
    udp_ctrl_pkg::word_t         s_axil_rdata_o;
    logic [1:0]                  s_axil_rresp_o;
    logic                        s_axil_rvalid_o;
    logic                        s_axil_rready_i;
    udp_ctrl_pkg::board_params_t board_params_o;
    udp_ctrl_pkg::word_t         serial_number_o;
    udp_ctrl_pkg::dest_cell_t    dest_cell_o;
    udp_ctrl_pkg::cell_wr_t      cell_wr_o;

    // reference model of the register map
    udp_ctrl_pkg::board_params_t exp_board;
    udp_ctrl_pkg::dest_cell_t    exp_cell;
    udp_ctrl_pkg::cell_wr_t      exp_cell_wr;
    udp_ctrl_pkg::word_t         exp_rdata;
    logic                        cell_model_valid;
    logic                        check_reset;
    logic                        aw_hs;
    logic                        ar_hs;

    integer seed;
    int     errors    = 0;
    int     pass_cnt  = 0;
    int     fail_cnt  = 0;
    int     wr_issued = 0;
    int     rd_issued = 0;
    int     b_done    = 0;
    int     r_done    = 0;
    int     cycles;

    udp_ctrl_regs i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    assign aw_hs = s_axil_awvalid_i && s_axil_wvalid_i && s_axil_awready_o;
    assign ar_hs = s_axil_arvalid_i && s_axil_arready_o;

    // completed responses, compared with issued transactions after each test
    always @(posedge clk) begin
        if (s_axil_bvalid_o && s_axil_bready_i)
            b_done <= b_done + 1;
        if (s_axil_rvalid_o && s_axil_rready_i)
            r_done <= r_done + 1;
    end

    task automatic flag_error(input string msg);
        errors++;
        $display("error %0t: %s", $time, msg);
    endtask

    // byte lanes with their strobe set take the new data
    function automatic udp_ctrl_pkg::word_t lane_merge(udp_ctrl_pkg::word_t cur,
                                                       udp_ctrl_pkg::word_t data,
                                                       udp_ctrl_pkg::strb_t strb);
        udp_ctrl_pkg::word_t mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (cur & ~mask) | (data & mask);
    endfunction

    // 16-bit fields only see lanes 0 and 1
    function automatic logic [15:0] half_merge(logic [15:0] cur, udp_ctrl_pkg::word_t data,
                                               udp_ctrl_pkg::strb_t strb);
        udp_ctrl_pkg::word_t full;
        full = lane_merge({16'h0, cur}, data, strb & 4'b0011);
        return full[15:0];
    endfunction

    task automatic model_write(input udp_ctrl_pkg::reg_idx_t idx, input udp_ctrl_pkg::word_t data,
                               input udp_ctrl_pkg::strb_t strb);
        exp_cell_wr = '0;
        case (idx)
            5'h0: exp_board.control = lane_merge(exp_board.control, data, strb);
            5'h1: exp_board.mac[47:32] = half_merge(exp_board.mac[47:32], data, strb);
            5'h2: exp_board.mac[31:0] = lane_merge(exp_board.mac[31:0], data, strb);
            5'h3: exp_board.ip = lane_merge(exp_board.ip, data, strb);
            5'h4: exp_board.port = half_merge(exp_board.port, data, strb);
            5'h5: exp_cell.cell_addr = lane_merge(exp_cell.cell_addr, data, strb);
            5'h6: exp_cell.mac[47:32] = half_merge(exp_cell.mac[47:32], data, strb);
            5'h7: exp_cell.mac[31:0] = lane_merge(exp_cell.mac[31:0], data, strb);
            5'h8: exp_cell.ip = lane_merge(exp_cell.ip, data, strb);
            5'h9: exp_cell.port = half_merge(exp_cell.port, data, strb);
            // command word only fires with lane 0 strobed
            5'hA: begin
                if (strb[0])
                    exp_cell_wr = data[2:0];
            end
            default: ;
        endcase
    endtask

    function automatic udp_ctrl_pkg::word_t model_read(udp_ctrl_pkg::reg_idx_t idx);
        case (idx)
            5'h0: return exp_board.control;
            5'h1: return {16'h0, exp_board.mac[47:32]};
            5'h2: return exp_board.mac[31:0];
            5'h3: return exp_board.ip;
            5'h4: return {16'h0, exp_board.port};
            5'h5: return exp_cell.cell_addr;
            5'h6: return {16'h0, exp_cell.mac[47:32]};
            5'h7: return exp_cell.mac[31:0];
            5'h8: return exp_cell.ip;
            5'h9: return {16'h0, exp_cell.port};
            5'hB: return udp_ctrl_pkg::SERIAL_NUMBER;
            default: return '0;
        endcase
    endfunction

    `include "axil_bfm_tasks.svh"

    task automatic close_test(input string name, input int err_mark);
        assert (b_done == wr_issued && r_done == rd_issued) else begin
            errors++;
            $display("responses seen do not match the transactions issued in test %s", name);
        end
        if (errors == err_mark) begin
            pass_cnt++;
            $display("test %s: pass", name);
        end else begin
            fail_cnt++;
            $display("test %s: fail", name);
        end
    endtask

    reset_state: assert property (@(posedge clk) disable iff (!reset_n)
        check_reset |-> board_params_o == exp_board && cell_wr_o == '0 && !s_axil_bvalid_o
                        && !s_axil_rvalid_o && s_axil_arready_o && !s_axil_awready_o
                        && !s_axil_wready_o)
        else flag_error("outputs differ from reset values");

    // aw and w channels are accepted on the same cycle
    ready_pair: assert property (@(posedge clk) disable iff (!reset_n)
        s_axil_wready_o == s_axil_awready_o)
        else flag_error("wready differs from awready");

    serial_fixed: assert property (@(posedge clk) disable iff (!reset_n)
        serial_number_o == udp_ctrl_pkg::SERIAL_NUMBER)
        else flag_error("serial number output wrong");

    // register outputs change only on the edge that raises bvalid
    board_update: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(s_axil_bvalid_o) |-> board_params_o == exp_board)
        else flag_error("board parameters differ from model");

    board_quiet: assert property (@(posedge clk) disable iff (!reset_n)
        !$stable(board_params_o) |-> $rose(s_axil_bvalid_o))
        else flag_error("board parameters changed apart from a write response");

    cell_update: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(s_axil_bvalid_o) && cell_model_valid |-> dest_cell_o == exp_cell)
        else flag_error("destination cell differs from model");

    // pulse lasts exactly the cycle after bvalid rises
    cell_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        cell_wr_o == ($rose(s_axil_bvalid_o) ? exp_cell_wr : 3'b000))
        else flag_error("cell write strobe wrong");

    read_value: assert property (@(posedge clk) disable iff (!reset_n)
        s_axil_rvalid_o && s_axil_rready_i |-> s_axil_rdata_o == exp_rdata
                                               && s_axil_rresp_o == udp_ctrl_pkg::RESP_OKAY)
        else flag_error("read data or response wrong");

    wr_resp_okay: assert property (@(posedge clk) disable iff (!reset_n)
        s_axil_bvalid_o |-> s_axil_bresp_o == udp_ctrl_pkg::RESP_OKAY)
        else flag_error("write response not OKAY");

    wr_latency_lo: assert property (@(posedge clk) disable iff (!reset_n)
        aw_hs |=> !s_axil_bvalid_o)
        else flag_error("bvalid too early after write handshake");

    wr_latency_hi: assert property (@(posedge clk) disable iff (!reset_n)
        $past(aw_hs, 2) |-> s_axil_bvalid_o)
        else flag_error("bvalid late after write handshake");

    rd_latency_lo: assert property (@(posedge clk) disable iff (!reset_n)
        ar_hs |=> !s_axil_rvalid_o)
        else flag_error("rvalid too early after read handshake");

    rd_latency_hi: assert property (@(posedge clk) disable iff (!reset_n)
        $past(ar_hs, 2) |-> s_axil_rvalid_o)
        else flag_error("rvalid late after read handshake");

    // back-pressure holds the response, and each one is taken once
    b_held: assert property (@(posedge clk) disable iff (!reset_n)
        s_axil_bvalid_o && !s_axil_bready_i |=> s_axil_bvalid_o && $stable(s_axil_bresp_o))
        else flag_error("write response dropped or changed before bready");

    r_held: assert property (@(posedge clk) disable iff (!reset_n)
        s_axil_rvalid_o && !s_axil_rready_i |=> s_axil_rvalid_o && $stable(s_axil_rdata_o)
                                                && $stable(s_axil_rresp_o))
        else flag_error("read response dropped or changed before rready");

    b_once: assert property (@(posedge clk) disable iff (!reset_n)
        s_axil_bvalid_o && s_axil_bready_i |=> !s_axil_bvalid_o)
        else flag_error("write response repeated");

    r_once: assert property (@(posedge clk) disable iff (!reset_n)
        s_axil_rvalid_o && s_axil_rready_i |=> !s_axil_rvalid_o)
        else flag_error("read response repeated");

    // run limit, sized for about 70 transactions with margin
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int err_mark;
        seed             = 32'h9eae;
        reset_n          = 1'b0;
        s_axil_awaddr_i  = '0;
        s_axil_awvalid_i = 1'b0;
        s_axil_wdata_i   = '0;
        s_axil_wstrb_i   = '0;
        s_axil_wvalid_i  = 1'b0;
        s_axil_bready_i  = 1'b0;
        s_axil_araddr_i  = '0;
        s_axil_arvalid_i = 1'b0;
        s_axil_rready_i  = 1'b0;
        exp_board        = '{control: '0, mac: udp_ctrl_pkg::MAC_BOARD_DEFAULT,
                             ip: udp_ctrl_pkg::IP_BOARD_DEFAULT,
                             port: udp_ctrl_pkg::PORT_BOARD_DEFAULT};
        exp_cell_wr      = '0;
        exp_rdata        = '0;
        cell_model_valid = 1'b0;
        check_reset      = 1'b0;
        repeat (10) @(negedge clk);
        reset_n = 1'b1;

        err_mark = errors;
        check_reset = 1'b1;
        @(negedge clk);
        check_reset = 1'b0;
        close_test("reset values", err_mark);

        err_mark = errors;
        for (int idx = 0; idx < 5; idx++) begin
            repeat (2) axil_write(udp_ctrl_pkg::reg_idx_t'(idx), $random(seed),
                                  udp_ctrl_pkg::strb_t'($random(seed)));
            axil_read(udp_ctrl_pkg::reg_idx_t'(idx));
        end
        close_test("board writes", err_mark);

        err_mark = errors;
        // staging has no reset, fill every field before comparing
        for (int idx = 5; idx < 10; idx++)
            axil_write(udp_ctrl_pkg::reg_idx_t'(idx), $random(seed), 4'hF);
        cell_model_valid = 1'b1;
        for (int idx = 5; idx < 10; idx++) begin
            axil_write(udp_ctrl_pkg::reg_idx_t'(idx), $random(seed),
                       udp_ctrl_pkg::strb_t'($random(seed)));
            axil_read(udp_ctrl_pkg::reg_idx_t'(idx));
        end
        axil_write(udp_ctrl_pkg::REG_CELL_WR, 32'h0000_0005, 4'h1);
        // lane 0 not strobed, no pulse expected
        axil_write(udp_ctrl_pkg::REG_CELL_WR, 32'hFFFF_FFFF, 4'hE);
        axil_write(udp_ctrl_pkg::REG_CELL_WR, 32'hA5A5_A5A7, 4'hF);
        axil_read(udp_ctrl_pkg::REG_CELL_WR);
        close_test("destination staging", err_mark);

        err_mark = errors;
        axil_read(udp_ctrl_pkg::REG_SERIAL);
        axil_write(udp_ctrl_pkg::REG_SERIAL, $random(seed), 4'hF);
        axil_read(udp_ctrl_pkg::REG_SERIAL);
        axil_write(5'h0C, $random(seed), 4'hF);
        axil_write(5'h1F, $random(seed), 4'hF);
        for (int idx = 12; idx < 32; idx++)
            axil_read(udp_ctrl_pkg::reg_idx_t'(idx));
        close_test("serial and unmapped", err_mark);

        err_mark = errors;
        repeat (4) begin
            axil_write(udp_ctrl_pkg::REG_IP_BOARD, $random(seed), 4'hF);
            axil_read(udp_ctrl_pkg::REG_IP_BOARD);
            axil_read(udp_ctrl_pkg::REG_SERIAL);
        end
        close_test("back-pressure", err_mark);

        $display("tests ok %0d, tests failing %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: source/udp_ctrl_regs.sv
`timescale 1ns/1ps

module udp_ctrl_regs (
    input  logic                        clk,
    input  logic                        reset_n,
    input  udp_ctrl_pkg::axil_addr_t    s_axil_awaddr_i,
    input  logic                        s_axil_awvalid_i,
    output logic                        s_axil_awready_o,
    input  udp_ctrl_pkg::word_t         s_axil_wdata_i,
    input  udp_ctrl_pkg::strb_t         s_axil_wstrb_i,
    input  logic                        s_axil_wvalid_i,
    output logic                        s_axil_wready_o,
    output logic [1:0]                  s_axil_bresp_o,
    output logic                        s_axil_bvalid_o,
    input  logic                        s_axil_bready_i,
    input  udp_ctrl_pkg::axil_addr_t    s_axil_araddr_i,
    input  logic                        s_axil_arvalid_i,
    output logic                        s_axil_arready_o,
    output udp_ctrl_pkg::word_t         s_axil_rdata_o,
    output logic [1:0]                  s_axil_rresp_o,
    output logic                        s_axil_rvalid_o,
    input  logic                        s_axil_rready_i,
    // core parameters
    output udp_ctrl_pkg::board_params_t board_params_o,
    output udp_ctrl_pkg::word_t         serial_number_o,
    output udp_ctrl_pkg::dest_cell_t    dest_cell_o,
    output udp_ctrl_pkg::cell_wr_t      cell_wr_o
);

    udp_ctrl_pkg::reg_wr_req_t wr_req;
    udp_ctrl_pkg::reg_rd_req_t rd_req;
    udp_ctrl_pkg::word_t       board_rd_data;
    udp_ctrl_pkg::word_t       cell_rd_data;
    udp_ctrl_pkg::word_t       rd_data;

    // banks return zero on a miss, so a plain OR selects the owner
    assign rd_data = board_rd_data | cell_rd_data;

    axil_reg_slave i_axil_reg_slave (
        .clk              (clk),
        .reset_n          (reset_n),
        .s_axil_awaddr_i  (s_axil_awaddr_i),
        .s_axil_awvalid_i (s_axil_awvalid_i),
        .s_axil_awready_o (s_axil_awready_o),
        .s_axil_wdata_i   (s_axil_wdata_i),
        .s_axil_wstrb_i   (s_axil_wstrb_i),
        .s_axil_wvalid_i  (s_axil_wvalid_i),
        .s_axil_wready_o  (s_axil_wready_o),
        .s_axil_bresp_o   (s_axil_bresp_o),
        .s_axil_bvalid_o  (s_axil_bvalid_o),
        .s_axil_bready_i  (s_axil_bready_i),
        .s_axil_araddr_i  (s_axil_araddr_i),
        .s_axil_arvalid_i (s_axil_arvalid_i),
        .s_axil_arready_o (s_axil_arready_o),
        .s_axil_rdata_o   (s_axil_rdata_o),
        .s_axil_rresp_o   (s_axil_rresp_o),
        .s_axil_rvalid_o  (s_axil_rvalid_o),
        .s_axil_rready_i  (s_axil_rready_i),
        .rd_data_i        (rd_data),
        .wr_req_o         (wr_req),
        .rd_req_o         (rd_req)
    );

    board_param_regs i_board_param_regs (
        .clk             (clk),
        .reset_n         (reset_n),
        .wr_req_i        (wr_req),
        .rd_idx_i        (rd_req.index),
        .params_o        (board_params_o),
        .serial_number_o (serial_number_o),
        .rd_data_o       (board_rd_data)
    );

    dest_cell_stage i_dest_cell_stage (
        .clk       (clk),
        .reset_n   (reset_n),
        .wr_req_i  (wr_req),
        .rd_idx_i  (rd_req.index),
        .cell_o    (dest_cell_o),
        .cell_wr_o (cell_wr_o),
        .rd_data_o (cell_rd_data)
    );

endmodule

// File: source/dest_cell_stage.sv
`timescale 1ns/1ps

module dest_cell_stage (
    input  logic                      clk,
    input  logic                      reset_n,
    input  udp_ctrl_pkg::reg_wr_req_t wr_req_i,
    input  udp_ctrl_pkg::reg_idx_t    rd_idx_i,
    output udp_ctrl_pkg::dest_cell_t  cell_o,
    output udp_ctrl_pkg::cell_wr_t    cell_wr_o,
    output udp_ctrl_pkg::word_t       rd_data_o
);

    udp_ctrl_pkg::dest_cell_t cell_q;
    udp_ctrl_pkg::cell_wr_t   cell_wr_q;
    logic                     cell_cmd;

    // command write, only the low lane carries the field strobes
    assign cell_cmd = wr_req_i.valid && (wr_req_i.index == udp_ctrl_pkg::REG_CELL_WR)
                      && wr_req_i.strb[0];

    // staging fields, filled by software before the command
    always_ff @(posedge clk) begin
        if (wr_req_i.valid) begin
            case (wr_req_i.index)
                udp_ctrl_pkg::REG_CELL_ADDR:
                    cell_q.cell_addr <= udp_ctrl_pkg::merge_word(cell_q.cell_addr,
                                                                 wr_req_i.data, wr_req_i.strb);
                udp_ctrl_pkg::REG_MAC_DEST_HI:
                    cell_q.mac[47:32] <= udp_ctrl_pkg::merge_half(cell_q.mac[47:32],
                                                                  wr_req_i.data, wr_req_i.strb);
                udp_ctrl_pkg::REG_MAC_DEST_LO:
                    cell_q.mac[31:0] <= udp_ctrl_pkg::merge_word(cell_q.mac[31:0],
                                                                 wr_req_i.data, wr_req_i.strb);
                udp_ctrl_pkg::REG_IP_DEST:
                    cell_q.ip <= udp_ctrl_pkg::merge_word(cell_q.ip,
                                                          wr_req_i.data, wr_req_i.strb);
                udp_ctrl_pkg::REG_PORT_DEST:
                    cell_q.port <= udp_ctrl_pkg::merge_half(cell_q.port,
                                                            wr_req_i.data, wr_req_i.strb);
                default: ;
            endcase
        end
    end

    // one-cycle strobe toward the destination table
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            cell_wr_q <= '0;
        else if (cell_cmd)
            cell_wr_q <= wr_req_i.data[2:0];
        else
            cell_wr_q <= '0;
    end

    // staged values read back, the command word reads zero
    always_comb begin
        case (rd_idx_i)
            udp_ctrl_pkg::REG_CELL_ADDR:   rd_data_o = cell_q.cell_addr;
            udp_ctrl_pkg::REG_MAC_DEST_HI: rd_data_o = {16'h0, cell_q.mac[47:32]};
            udp_ctrl_pkg::REG_MAC_DEST_LO: rd_data_o = cell_q.mac[31:0];
            udp_ctrl_pkg::REG_IP_DEST:     rd_data_o = cell_q.ip;
            udp_ctrl_pkg::REG_PORT_DEST:   rd_data_o = {16'h0, cell_q.port};
            default:                       rd_data_o = '0;
        endcase
    end

    assign cell_o    = cell_q;
    assign cell_wr_o = cell_wr_q;

    // a strobe must never commit unwritten staging into the table
    a_cell_staged: assert property (
        @(posedge clk) disable iff (!reset_n)
        (|cell_wr_o) |-> !$isunknown(cell_o.cell_addr)
                         && (!cell_wr_o[0] || !$isunknown(cell_o.mac))
                         && (!cell_wr_o[1] || !$isunknown(cell_o.ip))
                         && (!cell_wr_o[2] || !$isunknown(cell_o.port))
    ) else $error("cell write strobe with unknown staged field");

endmodule

// File: source/board_param_regs.sv
`timescale 1ns/1ps

module board_param_regs (
    input  logic                        clk,
    input  logic                        reset_n,
    input  udp_ctrl_pkg::reg_wr_req_t   wr_req_i,
    input  udp_ctrl_pkg::reg_idx_t      rd_idx_i,
    output udp_ctrl_pkg::board_params_t params_o,
    output udp_ctrl_pkg::word_t         serial_number_o,
    output udp_ctrl_pkg::word_t         rd_data_o
);

    udp_ctrl_pkg::board_params_t params_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            params_q.control <= '0;
            params_q.mac     <= udp_ctrl_pkg::MAC_BOARD_DEFAULT;
            params_q.ip      <= udp_ctrl_pkg::IP_BOARD_DEFAULT;
            params_q.port    <= udp_ctrl_pkg::PORT_BOARD_DEFAULT;
        end else if (wr_req_i.valid) begin
            // indices outside the bank fall through untouched
            case (wr_req_i.index)
                udp_ctrl_pkg::REG_CONTROL:
                    params_q.control <= udp_ctrl_pkg::merge_word(params_q.control,
                                                                 wr_req_i.data, wr_req_i.strb);
                // mac bytes 5..4 sit in the low half of the word
                udp_ctrl_pkg::REG_MAC_BOARD_HI:
                    params_q.mac[47:32] <= udp_ctrl_pkg::merge_half(params_q.mac[47:32],
                                                                    wr_req_i.data, wr_req_i.strb);
                udp_ctrl_pkg::REG_MAC_BOARD_LO:
                    params_q.mac[31:0] <= udp_ctrl_pkg::merge_word(params_q.mac[31:0],
                                                                   wr_req_i.data, wr_req_i.strb);
                udp_ctrl_pkg::REG_IP_BOARD:
                    params_q.ip <= udp_ctrl_pkg::merge_word(params_q.ip,
                                                            wr_req_i.data, wr_req_i.strb);
                udp_ctrl_pkg::REG_PORT_BOARD:
                    params_q.port <= udp_ctrl_pkg::merge_half(params_q.port,
                                                              wr_req_i.data, wr_req_i.strb);
                default: ;
            endcase
        end
    end

    // zero unless the index belongs to this bank
    always_comb begin
        case (rd_idx_i)
            udp_ctrl_pkg::REG_CONTROL:      rd_data_o = params_q.control;
            udp_ctrl_pkg::REG_MAC_BOARD_HI: rd_data_o = {16'h0, params_q.mac[47:32]};
            udp_ctrl_pkg::REG_MAC_BOARD_LO: rd_data_o = params_q.mac[31:0];
            udp_ctrl_pkg::REG_IP_BOARD:     rd_data_o = params_q.ip;
            udp_ctrl_pkg::REG_PORT_BOARD:   rd_data_o = {16'h0, params_q.port};
            // serial is fixed, writes to it are dropped above
            udp_ctrl_pkg::REG_SERIAL:       rd_data_o = udp_ctrl_pkg::SERIAL_NUMBER;
            default:                        rd_data_o = '0;
        endcase
    end

    assign params_o        = params_q;
    assign serial_number_o = udp_ctrl_pkg::SERIAL_NUMBER;

    // every field has a reset value, so no x may ever reach the core
    a_params_known: assert property (
        @(posedge clk) disable iff (!reset_n)
        !$isunknown(params_o)
    ) else $error("board parameters unknown after reset");

endmodule

// File: source/axil_reg_slave.sv
`timescale 1ns/1ps

module axil_reg_slave (
    input  logic                      clk,
    input  logic                      reset_n,
    // write address and data
    input  udp_ctrl_pkg::axil_addr_t  s_axil_awaddr_i,
    input  logic                      s_axil_awvalid_i,
    output logic                      s_axil_awready_o,
    input  udp_ctrl_pkg::word_t       s_axil_wdata_i,
    input  udp_ctrl_pkg::strb_t       s_axil_wstrb_i,
    input  logic                      s_axil_wvalid_i,
    output logic                      s_axil_wready_o,
    // write response
    output logic [1:0]                s_axil_bresp_o,
    output logic                      s_axil_bvalid_o,
    input  logic                      s_axil_bready_i,
    // read address and data
    input  udp_ctrl_pkg::axil_addr_t  s_axil_araddr_i,
    input  logic                      s_axil_arvalid_i,
    output logic                      s_axil_arready_o,
    output udp_ctrl_pkg::word_t       s_axil_rdata_o,
    output logic [1:0]                s_axil_rresp_o,
    output logic                      s_axil_rvalid_o,
    input  logic                      s_axil_rready_i,
    // register side
    input  udp_ctrl_pkg::word_t       rd_data_i,
    output udp_ctrl_pkg::reg_wr_req_t wr_req_o,
    output udp_ctrl_pkg::reg_rd_req_t rd_req_o
);

    typedef enum logic {WR_IDLE, WR_RESP} wr_state_t;
    typedef enum logic {RD_IDLE, RD_RESP} rd_state_t;

    wr_state_t                wr_state;
    rd_state_t                rd_state;
    logic                     awready_q;
    logic                     wr_valid_q;
    logic                     bvalid_q;
    logic                     wr_hs;
    udp_ctrl_pkg::reg_idx_t   wr_idx_q;
    udp_ctrl_pkg::word_t      wr_data_q;
    udp_ctrl_pkg::strb_t      wr_strb_q;
    logic                     rd_valid_q;
    logic                     rvalid_q;
    logic                     rd_hs;
    udp_ctrl_pkg::reg_idx_t   rd_idx_q;
    udp_ctrl_pkg::word_t      rdata_q;

    // aw and w are accepted together, on one shared ready
    assign wr_hs = awready_q && s_axil_awvalid_i && s_axil_wvalid_i;
    assign rd_hs = (rd_state == RD_IDLE) && s_axil_arvalid_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_state   <= WR_IDLE;
            awready_q  <= 1'b0;
            wr_valid_q <= 1'b0;
            bvalid_q   <= 1'b0;
        end else begin
            wr_valid_q <= wr_hs;
            case (wr_state)
                WR_IDLE: begin
                    if (wr_hs) begin
                        awready_q <= 1'b0;
                        wr_state  <= WR_RESP;
                    end else begin
                        // ready pulses once both channels present
                        awready_q <= s_axil_awvalid_i && s_axil_wvalid_i;
                    end
                end
                WR_RESP: begin
                    // bvalid lands on the edge the bank takes the write
                    if (wr_valid_q) begin
                        bvalid_q <= 1'b1;
                    end else if (bvalid_q && s_axil_bready_i) begin
                        bvalid_q <= 1'b0;
                        wr_state <= WR_IDLE;
                    end
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    // write request payload
    always_ff @(posedge clk) begin
        if (wr_hs) begin
            wr_idx_q  <= s_axil_awaddr_i[6:2];
            wr_data_q <= s_axil_wdata_i;
            wr_strb_q <= s_axil_wstrb_i;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_state   <= RD_IDLE;
            rd_valid_q <= 1'b0;
            rvalid_q   <= 1'b0;
        end else begin
            rd_valid_q <= rd_hs;
            case (rd_state)
                RD_IDLE: begin
                    if (rd_hs)
                        rd_state <= RD_RESP;
                end
                RD_RESP: begin
                    if (rd_valid_q) begin
                        rvalid_q <= 1'b1;
                    end else if (rvalid_q && s_axil_rready_i) begin
                        rvalid_q <= 1'b0;
                        rd_state <= RD_IDLE;
                    end
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    // read index held for the banks, data sampled one edge later
    always_ff @(posedge clk) begin
        if (rd_hs)
            rd_idx_q <= s_axil_araddr_i[6:2];
        if (rd_valid_q)
            rdata_q <= rd_data_i;
    end

    assign s_axil_awready_o = awready_q;
    assign s_axil_wready_o  = awready_q;
    assign s_axil_bvalid_o  = bvalid_q;
    assign s_axil_bresp_o   = udp_ctrl_pkg::RESP_OKAY;
    assign s_axil_arready_o = (rd_state == RD_IDLE);
    assign s_axil_rvalid_o  = rvalid_q;
    assign s_axil_rdata_o   = rdata_q;
    assign s_axil_rresp_o   = udp_ctrl_pkg::RESP_OKAY;

    assign wr_req_o = '{valid: wr_valid_q, index: wr_idx_q, data: wr_data_q, strb: wr_strb_q};
    assign rd_req_o = '{valid: rd_valid_q, index: rd_idx_q};

    // response held under back-pressure
    a_bvalid_hold: assert property (
        @(posedge clk) disable iff (!reset_n)
        s_axil_bvalid_o && !s_axil_bready_i |=> s_axil_bvalid_o
    ) else $error("bvalid dropped before bready");

    a_rvalid_hold: assert property (
        @(posedge clk) disable iff (!reset_n)
        s_axil_rvalid_o && !s_axil_rready_i |=> s_axil_rvalid_o && $stable(s_axil_rdata_o)
    ) else $error("rvalid or rdata changed before rready");

endmodule

// File: source/udp_ctrl_pkg.sv
package udp_ctrl_pkg;

    // bus side widths
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;
    // word index, byte address bits 6..2
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  axil_addr_t;

    // network field widths
    typedef logic [47:0] mac_t;
    typedef logic [31:0] ip_t;
    typedef logic [15:0] udp_port_t;
    // bit 0 mac, bit 1 ip, bit 2 port
    typedef logic [2:0]  cell_wr_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t index;
        word_t    data;
        strb_t    strb;
    } reg_wr_req_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t index;
    } reg_rd_req_t;

    typedef struct packed {
        word_t     control;
        mac_t      mac;
        ip_t       ip;
        udp_port_t port;
    } board_params_t;

    typedef struct packed {
        word_t     cell_addr;
        mac_t      mac;
        ip_t       ip;
        udp_port_t port;
    } dest_cell_t;

    // register map, word indices
    localparam reg_idx_t REG_CONTROL       = 5'h0;
    localparam reg_idx_t REG_MAC_BOARD_HI  = 5'h1;
    localparam reg_idx_t REG_MAC_BOARD_LO  = 5'h2;
    localparam reg_idx_t REG_IP_BOARD      = 5'h3;
    localparam reg_idx_t REG_PORT_BOARD    = 5'h4;
    localparam reg_idx_t REG_CELL_ADDR     = 5'h5;
    localparam reg_idx_t REG_MAC_DEST_HI   = 5'h6;
    localparam reg_idx_t REG_MAC_DEST_LO   = 5'h7;
    localparam reg_idx_t REG_IP_DEST       = 5'h8;
    localparam reg_idx_t REG_PORT_DEST     = 5'h9;
    localparam reg_idx_t REG_CELL_WR       = 5'hA;
    localparam reg_idx_t REG_SERIAL        = 5'hB;

    // board identity after reset
    localparam mac_t      MAC_BOARD_DEFAULT  = 48'h0123_4567_8901;
    localparam ip_t       IP_BOARD_DEFAULT   = 32'hC0A8_0001;
    localparam udp_port_t PORT_BOARD_DEFAULT = 16'h1234;
    localparam word_t     SERIAL_NUMBER      = 32'h5EED_0B41;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // full word, every lane with its strobe set is replaced
    function automatic word_t merge_word(word_t cur, word_t wdata, strb_t strb);
        word_t res;
        res = cur;
        for (int i = 0; i < 4; i++) begin
            if (strb[i])
                res[i*8 +: 8] = wdata[i*8 +: 8];
        end
        return res;
    endfunction

    // 16-bit fields live in data bits 15..0, upper strobes do nothing
    function automatic logic [15:0] merge_half(logic [15:0] cur, word_t wdata, strb_t strb);
        logic [15:0] res;
        res = cur;
        if (strb[0])
            res[7:0] = wdata[7:0];
        if (strb[1])
            res[15:8] = wdata[15:8];
        return res;
    endfunction

endpackage
